// ==== hdl/op_pkg.sv ====
package op_pkg;

	// ======================================================================
	// Operation kinds carried by every ROB entry
	// ======================================================================

	typedef enum logic [1:0] {
		op_alu       = 2'd0,
		op_branch    = 2'd1,
		op_interrupt = 2'd2
	} op_kind_e;

	// ======================================================================
	// The 16-bit operation word and its two decodings
	// ======================================================================

	// Branch view, with the predicted direction on top and the target below it
	typedef struct packed {
		logic        pred_taken;
		logic [14:0] target;
	} branch_view_t;

	// Interrupt view, with the priority level on top and then the cause code
	typedef struct packed {
		logic [2:0] level;
		logic [7:0] cause;
		logic [4:0] reserved;
	} irq_view_t;

	// The same 16 bits, read as a branch or as an interrupt by the kind field
	typedef union packed {
		branch_view_t br;
		irq_view_t    irq;
	} op_word_u;

endpackage

// ==== hdl/rob_pkg.sv ====
package rob_pkg;

	// ======================================================================
	// ROB bookkeeping shared by the store and the helper blocks
	// ======================================================================

	// Allocation group size
	// A tail that is rebuilt after a stomp is rounded up to a multiple of this
	// The store also keeps this many slots free as the full margin
	parameter int GROUP = 4;

	// One ROB slot, 20 bits wide
	// Live means the slot holds an instruction that has not retired or been stomped
	// Done means an execution unit has reported the instruction as finished
	typedef struct packed {
		logic               live;
		logic               done;
		op_pkg::op_kind_e   kind;
		op_pkg::op_word_u   word;
	} rob_entry_t;

endpackage

// ==== hdl/rob_store.sv ====
`timescale 1ns/1ps

module rob_store #(
	parameter int ROB_ENTRIES = 16
) (
	input  logic                                     clk,
	input  logic                                     rst_n,
	input  logic                                     disp_valid,
	input  op_pkg::op_kind_e                         disp_kind,
	input  op_pkg::op_word_u                         disp_word,
	input  logic                                     done_valid,
	input  logic [$clog2(ROB_ENTRIES)-1:0]           done_ndx,
	input  logic                                     done_mispredict,
	input  logic [ROB_ENTRIES-1:0]                   robentry_stomp,
	input  logic [$clog2(ROB_ENTRIES)-1:0]           stail,
	input  logic                                     retire,
	output rob_pkg::rob_entry_t [ROB_ENTRIES-1:0]    rob,
	output logic [$clog2(ROB_ENTRIES)-1:0]           head0,
	output logic [$clog2(ROB_ENTRIES)-1:0]           tail0,
	output logic                                     full
);

	localparam int NDX_W = $clog2(ROB_ENTRIES);

	// Dispatch stops once this many slots sit between head and tail
	localparam int FULL_MARK = ROB_ENTRIES - rob_pkg::GROUP;

	// Pointers carry one extra bit on top that acts as the wrap flag
	// Equal indices with equal wrap bits mean an empty buffer
	logic [NDX_W:0] head_ext;
	logic [NDX_W:0] tail_ext;
	logic [NDX_W:0] occupancy;
	logic [NDX_W:0] stail_ext;
	logic [NDX_W-1:0] stail_dist;
	logic stomp_now;

	assign head0 = head_ext[NDX_W-1:0];
	assign tail0 = tail_ext[NDX_W-1:0];

	// Slots in use, counting stomped or skipped slots that head has not passed
	assign occupancy = tail_ext - head_ext;
	assign full = occupancy >= (NDX_W+1)'(FULL_MARK);

	// A mispredicted branch that is still in flight triggers the stomp
	assign stomp_now = done_valid && done_mispredict && rob[done_ndx].live &&
		rob[done_ndx].kind == op_pkg::op_branch;

	// The new tail is rebuilt from head, since stail never passes head
	// and its distance from head is therefore the new occupancy
	assign stail_dist = stail - head0;
	assign stail_ext = head_ext + {1'b0, stail_dist};

	// ======================================================================
	// Entry array and pointer updates
	// ======================================================================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			head_ext <= '0;
			tail_ext <= '0;
			for (int i = 0; i < ROB_ENTRIES; i++) begin
				rob[i].live <= 1'b0;
				rob[i].done <= 1'b0;
			end
		end else begin
			// Allocation at the tail
			// A stomp in the same cycle wins and the dispatch is lost
			if (stomp_now) begin
				tail_ext <= stail_ext;
			end else if (disp_valid && !full) begin
				rob[tail0].live <= 1'b1;
				rob[tail0].done <= 1'b0;
				rob[tail0].kind <= disp_kind;
				rob[tail0].word <= disp_word;
				tail_ext <= tail_ext + 1'b1;
			end

			// An execution unit reports the entry finished
			if (done_valid && rob[done_ndx].live)
				rob[done_ndx].done <= 1'b1;

			// Younger entries of a mispredicted branch drop out
			for (int i = 0; i < ROB_ENTRIES; i++) begin
				if (robentry_stomp[i])
					rob[i].live <= 1'b0;
			end

			// Head moves on whether the entry committed or was a dead slot
			if (retire) begin
				rob[head0].live <= 1'b0;
				head_ext <= head_ext + 1'b1;
			end
		end
	end

endmodule

// ==== hdl/rob_stomp.sv ====
`timescale 1ns/1ps

module rob_stomp #(
	parameter int ROB_ENTRIES = 16
) (
	input  logic [$clog2(ROB_ENTRIES)-1:0]           tail0,
	input  logic                                     done_valid,
	input  logic                                     done_mispredict,
	input  logic [$clog2(ROB_ENTRIES)-1:0]           done_ndx,
	input  rob_pkg::rob_entry_t [ROB_ENTRIES-1:0]    rob,
	output logic [ROB_ENTRIES-1:0]                   robentry_stomp
);

	localparam int NDX_W = $clog2(ROB_ENTRIES);

	logic             mispredict;
	logic [NDX_W-1:0] span;
	logic [NDX_W-1:0] offset;

	// Ages are measured as circular distance from the completing branch
	// Every slot whose distance lies strictly between zero and the tail
	// distance holds an instruction fetched down the wrong path
	always_comb begin
		mispredict = done_valid && done_mispredict && rob[done_ndx].live &&
			rob[done_ndx].kind == op_pkg::op_branch;
		span = tail0 - done_ndx;
		robentry_stomp = '0;
		offset = '0;
		for (int i = 0; i < ROB_ENTRIES; i++) begin
			offset = NDX_W'(i) - done_ndx;
			// The branch itself sits at offset zero and survives
			if (mispredict && offset != '0 && offset < span)
				robentry_stomp[i] = 1'b1;
		end
	end

endmodule

// ==== hdl/rob_stail.sv ====
`timescale 1ns/1ps

module rob_stail #(
	parameter int ROB_ENTRIES = 16
) (
	input  logic [$clog2(ROB_ENTRIES)-1:0]           head0,
	input  logic [$clog2(ROB_ENTRIES)-1:0]           tail0,
	input  logic [ROB_ENTRIES-1:0]                   robentry_stomp,
	input  rob_pkg::rob_entry_t [ROB_ENTRIES-1:0]    rob,
	output logic [$clog2(ROB_ENTRIES)-1:0]           stail
);

	localparam int NDX_W = $clog2(ROB_ENTRIES);

	// Mask that clears the low bits so the index lands on a group boundary
	localparam logic [NDX_W-1:0] ALIGN_MASK = ~NDX_W'(rob_pkg::GROUP - 1);

	logic             irq_held;
	logic             found;
	logic [NDX_W-1:0] ndx;
	logic [NDX_W-1:0] prev;

	always_comb begin
		irq_held = 1'b0;
		found = 1'b0;
		ndx = '0;
		prev = '0;
		stail = tail0;
		// A pending interrupt pins the tail where it is
		for (int i = 0; i < ROB_ENTRIES; i++) begin
			if (rob[i].live && rob[i].kind == op_pkg::op_interrupt)
				irq_held = 1'b1;
		end
		// Walk from head in age order and stop at the oldest run start
		for (int k = 0; k < ROB_ENTRIES; k++) begin
			ndx = head0 + NDX_W'(k);
			prev = ndx - 1'b1;
			if (!irq_held && !found && robentry_stomp[ndx] && !robentry_stomp[prev]) begin
				// Round up to the next allocation group, wrapping at the top
				stail = (ndx + NDX_W'(rob_pkg::GROUP - 1)) & ALIGN_MASK;
				found = 1'b1;
			end
		end
	end

endmodule

// ==== hdl/rob_commit.sv ====
`timescale 1ns/1ps

module rob_commit #(
	parameter int ROB_ENTRIES = 16
) (
	input  logic                                     clk,
	input  logic                                     rst_n,
	input  logic [$clog2(ROB_ENTRIES)-1:0]           head0,
	input  logic [$clog2(ROB_ENTRIES)-1:0]           tail0,
	input  rob_pkg::rob_entry_t [ROB_ENTRIES-1:0]    rob,
	output logic                                     retire,
	output logic                                     commit_valid,
	output logic [$clog2(ROB_ENTRIES)-1:0]           commit_ndx,
	output op_pkg::op_kind_e                         commit_kind,
	output logic [14:0]                              commit_target,
	output logic                                     irq_valid,
	output logic [2:0]                               irq_level,
	output logic [7:0]                               irq_cause
);

	rob_pkg::rob_entry_t head_entry;
	logic                commit_now;
	logic [14:0]         target_dec;
	logic [2:0]          level_dec;
	logic [7:0]          cause_dec;

	assign head_entry = rob[head0];

	// Head moves past a finished entry or a dead slot, and waits on anything in flight
	assign retire = head0 != tail0 && (!head_entry.live || head_entry.done);
	assign commit_now = retire && head_entry.live;

	// Branches read the word as a target, interrupts read it as level and cause
	always_comb begin
		target_dec = '0;
		level_dec = '0;
		cause_dec = '0;
		if (head_entry.kind == op_pkg::op_branch)
			target_dec = head_entry.word.br.target;
		if (head_entry.kind == op_pkg::op_interrupt) begin
			level_dec = head_entry.word.irq.level;
			cause_dec = head_entry.word.irq.cause;
		end
	end

	// ======================================================================
	// Registered commit strobes and payload
	// ======================================================================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			commit_valid <= 1'b0;
			irq_valid <= 1'b0;
		end else begin
			commit_valid <= commit_now;
			irq_valid <= commit_now && head_entry.kind == op_pkg::op_interrupt;
		end
	end

	always_ff @(posedge clk) begin
		commit_ndx <= head0;
		commit_kind <= head_entry.kind;
		commit_target <= target_dec;
		irq_level <= level_dec;
		irq_cause <= cause_dec;
	end

endmodule

// ==== hdl/rob_top.sv ====
`timescale 1ns/1ps

module rob_top #(
	parameter int ROB_ENTRIES = 16
) (
	input  logic                              clk,
	input  logic                              rst_n,
	// Dispatch
	input  logic                              disp_valid,
	input  op_pkg::op_kind_e                  disp_kind,
	input  op_pkg::op_word_u                  disp_word,
	output logic [$clog2(ROB_ENTRIES)-1:0]    tail,
	output logic                              full,
	// Completion
	input  logic                              done_valid,
	input  logic [$clog2(ROB_ENTRIES)-1:0]    done_ndx,
	input  logic                              done_mispredict,
	// Commit
	output logic                              commit_valid,
	output logic [$clog2(ROB_ENTRIES)-1:0]    commit_ndx,
	output op_pkg::op_kind_e                  commit_kind,
	output logic [14:0]                       commit_target,
	output logic                              irq_valid,
	output logic [2:0]                        irq_level,
	output logic [7:0]                        irq_cause
);

	localparam int NDX_W = $clog2(ROB_ENTRIES);

	rob_pkg::rob_entry_t [ROB_ENTRIES-1:0] rob;
	logic [ROB_ENTRIES-1:0] robentry_stomp;
	logic [NDX_W-1:0] head0;
	logic [NDX_W-1:0] stail;
	logic retire;

	// Entry array and pointers, the tail goes straight out to dispatch
	rob_store #(.ROB_ENTRIES(ROB_ENTRIES)) rob_store_i (
		.clk(clk), .rst_n(rst_n),
		.disp_valid(disp_valid), .disp_kind(disp_kind), .disp_word(disp_word),
		.done_valid(done_valid), .done_ndx(done_ndx), .done_mispredict(done_mispredict),
		.robentry_stomp(robentry_stomp), .stail(stail), .retire(retire),
		.rob(rob), .head0(head0), .tail0(tail), .full(full)
	);

	rob_stomp #(.ROB_ENTRIES(ROB_ENTRIES)) rob_stomp_i (
		.tail0(tail), .done_valid(done_valid), .done_mispredict(done_mispredict),
		.done_ndx(done_ndx), .rob(rob), .robentry_stomp(robentry_stomp)
	);

	rob_stail #(.ROB_ENTRIES(ROB_ENTRIES)) rob_stail_i (
		.head0(head0), .tail0(tail), .robentry_stomp(robentry_stomp), .rob(rob),
		.stail(stail)
	);

	rob_commit #(.ROB_ENTRIES(ROB_ENTRIES)) rob_commit_i (
		.clk(clk), .rst_n(rst_n), .head0(head0), .tail0(tail), .rob(rob),
		.retire(retire), .commit_valid(commit_valid), .commit_ndx(commit_ndx),
		.commit_kind(commit_kind), .commit_target(commit_target),
		.irq_valid(irq_valid), .irq_level(irq_level), .irq_cause(irq_cause)
	);

endmodule

// ==== bench/rob_properties.sv ====
`timescale 1ns/1ps

module rob_properties #(
	parameter int ROB_ENTRIES = 16
) (
	input logic                           clk,
	input logic                           rst_n,
	input logic                           full,
	input logic                           stomp_now,
	input logic [$clog2(ROB_ENTRIES)-1:0] head0,
	input logic [$clog2(ROB_ENTRIES)-1:0] tail0
);

	localparam int NDX_W = $clog2(ROB_ENTRIES);

	// Reset empties the buffer, so full is low one cycle later
	assert property (@(posedge clk) !rst_n |=> !full)
		else $error("full is high right after reset");

	// A full buffer still keeps a group of free slots, so the pointers never meet
	assert property (@(posedge clk) disable iff (!rst_n) full |-> tail0 != head0)
		else $error("tail caught up with head while full");

	// After a stomp the tail sits on a group boundary, or stays put under an interrupt
	assert property (@(posedge clk) disable iff (!rst_n) stomp_now |=>
		(tail0 & NDX_W'(rob_pkg::GROUP - 1)) == '0 || tail0 == $past(tail0))
		else $error("tail after a stomp is neither aligned nor unchanged");

endmodule

bind rob_store rob_properties #(.ROB_ENTRIES(ROB_ENTRIES)) rob_properties_i (
	.clk(clk), .rst_n(rst_n), .full(full), .stomp_now(stomp_now),
	.head0(head0), .tail0(tail0)
);

// ==== bench/rob_tb.sv ====
`timescale 1ns/1ps

module rob_tb;

	localparam int ROB_ENTRIES = 16;
	localparam int NDX_W = $clog2(ROB_ENTRIES);
	// The five tests finish in a few hundred cycles, well inside this limit
	localparam int TIMEOUT_CYCLES = 3000;

	logic clk = 1'b0;
	logic rst_n, disp_valid, done_valid, done_mispredict, full, commit_valid, irq_valid;
	logic [NDX_W-1:0] tail, done_ndx, commit_ndx, model_tail;
	op_pkg::op_kind_e disp_kind, commit_kind;
	op_pkg::op_word_u disp_word;
	logic [14:0] commit_target;
	logic [2:0] irq_level;
	logic [7:0] irq_cause;
	int cycle_count = 0;

	// Each commit record holds, from the top bit down, the commit strobe, the irq strobe,
	// kind, index, target, level and cause
	logic [33:0] seen_q[$];
	logic [33:0] model_q[$];
	// Kind and word that each slot received at dispatch
	op_pkg::op_kind_e pend_kind [ROB_ENTRIES];
	op_pkg::op_word_u pend_word [ROB_ENTRIES];

	rob_top #(.ROB_ENTRIES(ROB_ENTRIES)) rob_top_i (.*);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the DUT stopped making progress", cycle_count);
			$display("TEST FAILED");
			$fatal(1, "timeout");
		end
	end

	// Commit outputs change at the rising edge and are read at the falling one
	always @(negedge clk) begin
		if (commit_valid || irq_valid)
			seen_q.push_back({commit_valid, irq_valid, commit_kind, commit_ndx,
				commit_target, irq_level, irq_cause});
	end

	// Branches expose their target, interrupts their level and cause, the rest zeros
	function automatic logic [33:0] commit_record(input logic [NDX_W-1:0] ndx);
		op_pkg::op_kind_e kind;
		op_pkg::op_word_u word;
		kind = pend_kind[ndx];
		word = pend_word[ndx];
		if (kind == op_pkg::op_branch)
			return {1'b1, 1'b0, kind, ndx, word.br.target, 3'd0, 8'd0};
		if (kind == op_pkg::op_interrupt)
			return {1'b1, 1'b1, kind, ndx, 15'd0, word.irq.level, word.irq.cause};
		return {1'b1, 1'b0, kind, ndx, 15'd0, 3'd0, 8'd0};
	endfunction

	task automatic check_value(input string test, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			$display("FAILED %s: expected 0x%0h, actual 0x%0h", test, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// Every drive lands 1 ns after a rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic dispatch(input op_pkg::op_kind_e kind, input op_pkg::op_word_u word,
		input logic taken);
		disp_valid = 1'b1;
		disp_kind = kind;
		disp_word = word;
		if (taken) begin
			pend_kind[model_tail] = kind;
			pend_word[model_tail] = word;
			model_tail = model_tail + 1'b1;
		end
		next_cycle();
		disp_valid = 1'b0;
	endtask

	task automatic complete(input logic [NDX_W-1:0] ndx, input logic mispredict);
		done_valid = 1'b1;
		done_ndx = ndx;
		done_mispredict = mispredict;
		next_cycle();
		done_valid = 1'b0;
		done_mispredict = 1'b0;
	endtask

	task automatic compare_commits(input string test);
		int n;
		n = model_q.size();
		while (seen_q.size() < n)
			next_cycle();
		// Room for head to skip every dead slot, so a stray commit would show up
		repeat (ROB_ENTRIES + 4) next_cycle();
		check_value(test, 64'(n), 64'(seen_q.size()));
		for (int i = 0; i < n; i++)
			check_value(test, 64'(model_q[i]), 64'(seen_q[i]));
		model_q.delete();
		seen_q.delete();
	endtask

	// ======================================================================
	// Directed tests
	// ======================================================================

	task automatic test_reset();
		check_value("test_reset", 0, 64'(tail));
		check_value("test_reset", 0, 64'(full));
		repeat (10) next_cycle();
		check_value("test_reset", 0, 64'(seen_q.size()));
	endtask

	task automatic test_in_order();
		logic [NDX_W-1:0] order [8];
		logic [NDX_W-1:0] swap;
		int j;
		for (int i = 0; i < 8; i++) begin
			order[i] = model_tail;
			model_q.push_back(0);
			dispatch(op_pkg::op_alu, 16'($urandom), 1'b1);
			model_q[i] = commit_record(order[i]);
		end
		// Shuffle so that completions arrive out of order
		for (int i = 7; i > 0; i--) begin
			j = $urandom % (i + 1);
			swap = order[i];
			order[i] = order[j];
			order[j] = swap;
		end
		for (int i = 0; i < 8; i++)
			complete(order[i], 1'b0);
		compare_commits("test_in_order");
	endtask

	task automatic test_stomp();
		logic [NDX_W-1:0] br;
		br = model_tail;
		dispatch(op_pkg::op_branch, 16'($urandom), 1'b1);
		repeat (5) dispatch(op_pkg::op_alu, 16'($urandom), 1'b1);
		// Two wrong path ops finish early and still must not commit
		complete(br + 1'b1, 1'b0);
		complete(br + 2'd2, 1'b0);
		complete(br, 1'b1);
		// First stomped slot is br plus one, rounded up to a group boundary
		model_tail = (br + NDX_W'(rob_pkg::GROUP)) & ~NDX_W'(rob_pkg::GROUP - 1);
		check_value("test_stomp", 64'(model_tail), 64'(tail));
		model_q.push_back(commit_record(br));
		compare_commits("test_stomp");
	endtask

	task automatic test_irq_hold();
		logic [NDX_W-1:0] irq;
		op_pkg::op_word_u word;
		irq = model_tail;
		word = 16'($urandom);
		word.irq.reserved = '0;
		dispatch(op_pkg::op_interrupt, word, 1'b1);
		dispatch(op_pkg::op_branch, 16'($urandom), 1'b1);
		repeat (3) dispatch(op_pkg::op_alu, 16'($urandom), 1'b1);
		complete(irq + 1'b1, 1'b1);
		// The live interrupt keeps the tail in place through the stomp
		check_value("test_irq_hold", 64'(model_tail), 64'(tail));
		complete(irq, 1'b0);
		model_q.push_back(commit_record(irq));
		model_q.push_back(commit_record(irq + 1'b1));
		compare_commits("test_irq_hold");
	endtask

	task automatic test_full();
		logic [NDX_W-1:0] first;
		first = model_tail;
		for (int i = 0; i < ROB_ENTRIES - rob_pkg::GROUP; i++)
			dispatch(op_pkg::op_alu, 16'($urandom), 1'b1);
		for (int i = 0; i < ROB_ENTRIES - rob_pkg::GROUP; i++)
			model_q.push_back(commit_record(first + NDX_W'(i)));
		check_value("test_full", 1, 64'(full));
		dispatch(op_pkg::op_alu, 16'($urandom), 1'b0);
		check_value("test_full", 64'(model_tail), 64'(tail));
		complete(first, 1'b0);
		while (seen_q.size() < 1)
			next_cycle();
		check_value("test_full", 0, 64'(full));
		for (int i = 1; i < ROB_ENTRIES - rob_pkg::GROUP; i++)
			complete(first + NDX_W'(i), 1'b0);
		compare_commits("test_full");
	endtask

	initial begin
		void'($urandom(32'h89890554));
		rst_n = 1'b0;
		disp_valid = 1'b0;
		disp_kind = op_pkg::op_alu;
		disp_word = '0;
		done_valid = 1'b0;
		done_ndx = '0;
		done_mispredict = 1'b0;
		model_tail = '0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		test_reset();
		test_in_order();
		test_stomp();
		test_irq_hold();
		test_full();
		$display("TEST OK");
		$finish;
	end

endmodule

// ==== sim.f ====
hdl/op_pkg.sv
hdl/rob_pkg.sv
hdl/rob_store.sv
hdl/rob_stomp.sv
hdl/rob_stail.sv
hdl/rob_commit.sv
hdl/rob_top.sv
bench/rob_properties.sv
bench/rob_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module rob_tb -f sim.f -o rob_sim \
	|| { echo "Verilator build failed"; exit 1; }
./obj_dir/rob_sim > sim.log 2>&1 || echo "Simulator returned an error status"
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TEST OK" sim.log || { echo "Simulation ended without a verdict"; exit 1; }
